/* build.f */
src/mult_pkg.sv
src/kogge_stone_adder.sv
src/partial_product_gen.sv
src/pp_reduction_tree.sv
src/multiplier_8x8.sv
tb/tb_clock_gen.sv
tb/tb_multiplier_8x8.sv

/* tb/tb_multiplier_8x8.sv */
`timescale 1ns/100ps

module tb_multiplier_8x8 import mult_pkg::*; ();

    localparam int CLK_PERIOD_NS = 10;
    localparam int RESET_CYCLES  = 5;
    localparam int DRIVE_DELAY   = 1;   // ns after the rising edge

    // vectors per test group
    localparam int N_ZERO_ONE    = 4 * 256;
    localparam int N_SINGLE_BIT  = OPERAND_W * OPERAND_W;
    localparam int N_CARRY       = 1 + 2 * 256;
    localparam int N_EXHAUSTIVE  = 256 * 256;
    localparam int N_RANDOM      = 2000;
    localparam int NUM_VECTORS   = N_ZERO_ONE + N_SINGLE_BIT + N_CARRY
                                 + N_EXHAUSTIVE + N_RANDOM;

    localparam int WATCHDOG_NS   = NUM_VECTORS * CLK_PERIOD_NS
                                 + RESET_CYCLES * CLK_PERIOD_NS + 1000;

    localparam logic [31:0] LFSR_SEED = 32'hb888ac66;
    localparam logic [31:0] LFSR_POLY = 32'h80200003;   // x^32 + x^22 + x^2 + x + 1

    logic           clk;
    logic           rst_n;

    mult_operands_t operands;
    product_t       product;

    // vector currently on the DUT inputs
    string          test_name;
    logic           vec_valid;
    logic           known_valid;    // known_exp holds a hand-derived value
    product_t       known_exp;

    int             vectors_sent;
    int             checks_done;
    logic [31:0]    lfsr_state;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) i_tb_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    multiplier_8x8 i_multiplier_8x8 (
        .operands (operands),
        .product  (product)
    );

    // expected product straight from integer multiplication
    function automatic product_t ref_product(input mult_operands_t ops);
        int unsigned a;
        int unsigned b;
        int unsigned full;
        a    = ops.multiplier;
        b    = ops.multiplicand;
        full = a * b;
        return full[PRODUCT_W-1:0];
    endfunction

    // one step of a right-shifting Galois LFSR
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_POLY;
        end
        return state >> 1;
    endfunction

    // one LFSR step per bit taken
    task automatic random_operand(output operand_t value);
        value = '0;
        for (int i = 0; i < OPERAND_W; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[OPERAND_W-2:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input product_t expected,
                               input product_t actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected 0x%04h actual 0x%04h at %0t",
                     name, expected, actual, $time);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // new vector every cycle, shortly after the rising edge
    task automatic drive_vector(input string name, input operand_t mplier,
                                input operand_t mcand);
        @(posedge clk);
        #(DRIVE_DELAY);
        test_name               = name;
        operands.multiplier     = mplier;
        operands.multiplicand   = mcand;
        vec_valid               = 1'b1;
        known_valid             = 1'b0;
        vectors_sent++;
    endtask

    task automatic drive_known(input string name, input operand_t mplier,
                               input operand_t mcand, input product_t expected);
        drive_vector(name, mplier, mcand);
        known_exp   = expected;
        known_valid = 1'b1;
    endtask

    // compare on the falling edge, 4 ns after the drive
    always @(negedge clk) begin : compare
        string label;
        if (rst_n && vec_valid) begin
            label = $sformatf("%s (%0d * %0d)", test_name,
                              operands.multiplier, operands.multiplicand);
            check_value(label, ref_product(operands), product);
            if (known_valid) begin
                check_value(label, known_exp, product);
            end
            checks_done++;
        end
    end

    initial begin : stimulus
        operand_t mp;
        operand_t mc;
        product_t bit_exp;

        operands     = '0;
        test_name    = "idle";
        vec_valid    = 1'b0;
        known_valid  = 1'b0;
        known_exp    = '0;
        vectors_sent = 0;
        checks_done  = 0;
        lfsr_state   = LFSR_SEED;

        wait (rst_n === 1'b1);

        // zero and one in both operand positions
        for (int v = 0; v < 256; v++) begin
            drive_known("zero_multiplier", 8'h00, v[7:0], '0);
            drive_known("zero_multiplicand", v[7:0], 8'h00, '0);
            drive_known("one_multiplier", 8'h01, v[7:0], {8'h00, v[7:0]});
            drive_known("one_multiplicand", v[7:0], 8'h01, {8'h00, v[7:0]});
        end

        // 2^i * 2^j lands on exactly bit i+j
        for (int i = 0; i < OPERAND_W; i++) begin
            for (int j = 0; j < OPERAND_W; j++) begin
                mp         = '0;
                mc         = '0;
                mp[i]      = 1'b1;
                mc[j]      = 1'b1;
                bit_exp    = '0;
                bit_exp[i+j] = 1'b1;
                drive_known("single_bit", mp, mc, bit_exp);
            end
        end

        // all-ones operand pushes carries through every level
        drive_known("carry_full", 8'hff, 8'hff, 16'd65025);
        for (int v = 0; v < 256; v++) begin
            drive_vector("carry_sweep_multiplier", 8'hff, v[7:0]);
            drive_vector("carry_sweep_multiplicand", v[7:0], 8'hff);
        end

        for (int a = 0; a < 256; a++) begin
            for (int b = 0; b < 256; b++) begin
                drive_vector("exhaustive", a[7:0], b[7:0]);
            end
        end

        // back to back random pairs
        for (int n = 0; n < N_RANDOM; n++) begin
            random_operand(mp);
            random_operand(mc);
            drive_vector("random", mp, mc);
        end

        // let the last vector reach its falling edge
        @(posedge clk);
        #(DRIVE_DELAY);
        vec_valid = 1'b0;

        if (checks_done != NUM_VECTORS || vectors_sent != NUM_VECTORS) begin
            $display("ERROR: %0d of %0d vectors driven, %0d compared",
                     vectors_sent, NUM_VECTORS, checks_done);
            $display("SOME TESTS FAILED");
            $fatal(1, "vector count mismatch");
        end else begin
            $display("%0d vectors compared", checks_done);
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

    // bound on run time, one cycle per vector plus reset and margin
    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("ERROR: simulation did not finish in time (%0d ns, %0d of %0d vectors)",
                 WATCHDOG_NS, vectors_sent, NUM_VECTORS);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    // free running clock, starts low
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset held low for a fixed number of rising edges
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;   // released just after the edge
    end

endmodule

/* src/multiplier_8x8.sv */
`timescale 1ns/100ps

module multiplier_8x8 import mult_pkg::*; (
    input  mult_operands_t operands,
    output product_t       product
);

    // bits of quad_lo below the weight of quad_hi
    localparam int LOW_W = QUAD_SUM_W - OPERAND_W;

    pp_rows_t  rows;
    quad_sum_t quad_lo;
    quad_sum_t quad_hi;
    quad_sum_t final_a;     // quad_lo shifted down under quad_hi
    quad_sum_t final_sum;

    partial_product_gen i_partial_product_gen (
        .operands (operands),
        .rows     (rows)
    );

    pp_reduction_tree i_pp_reduction_tree (
        .rows    (rows),
        .quad_lo (quad_lo),
        .quad_hi (quad_hi)
    );

    assign final_a = {{LOW_W{1'b0}}, quad_lo[QUAD_SUM_W-1:LOW_W]};

    // carry out stays low, 255 * 255 fits in 16 bits
    kogge_stone_adder #(
        .WIDTH (QUAD_SUM_W)
    ) i_final_adder (
        .a    (final_a),
        .b    (quad_hi),
        .sum  (final_sum),
        .cout ()
    );

    assign product = {final_sum, quad_lo[LOW_W-1:0]};

endmodule

/* src/pp_reduction_tree.sv */
`timescale 1ns/100ps

module pp_reduction_tree import mult_pkg::*; (
    input  pp_rows_t  rows,
    output quad_sum_t quad_lo,  // rows 0..3
    output quad_sum_t quad_hi   // rows 4..7
);

    localparam int NUM_PAIRS = OPERAND_W / 2;
    localparam int NUM_QUADS = NUM_PAIRS / 2;

    // level one operands and results
    operand_t  pair_a   [NUM_PAIRS];
    operand_t  pair_s   [NUM_PAIRS];
    logic      pair_c   [NUM_PAIRS];
    pair_sum_t pair_sum [NUM_PAIRS];

    // level two operands and results
    pair_sum_t quad_a   [NUM_QUADS];
    pair_sum_t quad_s   [NUM_QUADS];
    quad_sum_t quad_sum [NUM_QUADS];

    genvar pr;
    genvar qd;

    // level one: rows (2k, 2k+1), odd row sits one bit higher
    generate
        for (pr = 0; pr < NUM_PAIRS; pr++) begin : g_pair
            // even row minus its lsb, aligned under the odd row
            assign pair_a[pr] = {1'b0, rows[2*pr][OPERAND_W-1:1]};

            kogge_stone_adder #(
                .WIDTH (OPERAND_W)
            ) i_pair_adder (
                .a    (pair_a[pr]),
                .b    (rows[2*pr+1]),
                .sum  (pair_s[pr]),
                .cout (pair_c[pr])
            );

            assign pair_sum[pr] = {pair_c[pr], pair_s[pr], rows[2*pr][0]};
        end
    endgenerate

    // level two: pairs (2k, 2k+1), upper pair sits two bits higher
    generate
        for (qd = 0; qd < NUM_QUADS; qd++) begin : g_quad
            assign quad_a[qd] = {2'b00, pair_sum[2*qd][PAIR_SUM_W-1:2]};

            // carry out is never set, four rows of 8 bits stay below 2**12
            kogge_stone_adder #(
                .WIDTH (PAIR_SUM_W)
            ) i_quad_adder (
                .a    (quad_a[qd]),
                .b    (pair_sum[2*qd+1]),
                .sum  (quad_s[qd]),
                .cout ()
            );

            assign quad_sum[qd] = {quad_s[qd], pair_sum[2*qd][1:0]};
        end
    endgenerate

    assign quad_lo = quad_sum[0];
    assign quad_hi = quad_sum[1];

endmodule

/* src/partial_product_gen.sv */
`timescale 1ns/100ps

module partial_product_gen import mult_pkg::*; (
    input  mult_operands_t operands,
    output pp_rows_t       rows
);

    genvar row;

    // AND array, one row per multiplier bit
    generate
        for (row = 0; row < OPERAND_W; row++) begin : g_row
            assign rows[row] = operands.multiplicand
                             & {OPERAND_W{operands.multiplier[row]}};
        end
    endgenerate

endmodule

/* src/kogge_stone_adder.sv */
`timescale 1ns/100ps

module kogge_stone_adder #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    // number of prefix levels, spans 1, 2, 4 ...
    localparam int LEVELS = $clog2(WIDTH);

    // group generate / propagate per level, index 0 is the bitwise pair
    wire [WIDTH-1:0] g_lvl [0:LEVELS];
    wire [WIDTH-1:0] p_lvl [0:LEVELS];

    genvar lvl;
    genvar idx;

    // bitwise generate and propagate, lsb first
    assign g_lvl[0] = a & b;
    assign p_lvl[0] = a ^ b;

    generate
        for (lvl = 0; lvl < LEVELS; lvl++) begin : g_level
            localparam int SPAN = 1 << lvl;

            for (idx = 0; idx < WIDTH; idx++) begin : g_cell
                if (idx < SPAN) begin : g_pass
                    // group already complete down to bit 0
                    assign g_lvl[lvl+1][idx] = g_lvl[lvl][idx];
                    assign p_lvl[lvl+1][idx] = p_lvl[lvl][idx];
                end else if (idx < 2 * SPAN) begin : g_gray
                    // lower group reaches bit 0 so only the generate matters
                    assign g_lvl[lvl+1][idx] = g_lvl[lvl][idx]
                                             | (p_lvl[lvl][idx] & g_lvl[lvl][idx-SPAN]);
                    assign p_lvl[lvl+1][idx] = 1'b0;    // never read past this level
                end else begin : g_black
                    assign g_lvl[lvl+1][idx] = g_lvl[lvl][idx]
                                             | (p_lvl[lvl][idx] & g_lvl[lvl][idx-SPAN]);
                    assign p_lvl[lvl+1][idx] = p_lvl[lvl][idx] & p_lvl[lvl][idx-SPAN];
                end
            end
        end
    endgenerate

    // no carry in, so bit 0 is just the propagate
    assign sum[0] = p_lvl[0][0];

    generate
        for (idx = 1; idx < WIDTH; idx++) begin : g_sum
            // carry into bit idx is the group generate of bits idx-1 .. 0
            assign sum[idx] = p_lvl[0][idx] ^ g_lvl[LEVELS][idx-1];
        end
    endgenerate

    assign cout = g_lvl[LEVELS][WIDTH-1];   // group generate of the whole word

endmodule

/* src/mult_pkg.sv */
package mult_pkg;

    // operand and result widths
    localparam int OPERAND_W  = 8;
    localparam int PRODUCT_W  = 2 * OPERAND_W;

    // sum of two adjacent rows, row k+1 weighted by 2
    localparam int PAIR_SUM_W = OPERAND_W + 2;

    // sum of four adjacent rows, fits since 255 * 15 < 4096
    localparam int QUAD_SUM_W = OPERAND_W + 4;

    // one operand, also one partial-product row
    typedef logic [OPERAND_W-1:0]  operand_t;

    typedef logic [PRODUCT_W-1:0]  product_t;
    typedef logic [PAIR_SUM_W-1:0] pair_sum_t;
    typedef logic [QUAD_SUM_W-1:0] quad_sum_t;

    // row k = multiplicand gated by multiplier bit k
    typedef operand_t [OPERAND_W-1:0] pp_rows_t;

    typedef struct packed {
        operand_t multiplier;
        operand_t multiplicand;
    } mult_operands_t;

endpackage
